// ==== source/ooo_ctrl_pkg.sv ====
package ooo_ctrl_pkg;

    // graduation list geometry
    localparam int GL_DEPTH = 8;
    localparam int GL_IDX_W = 3;
    // a count has to reach GL_DEPTH itself
    localparam int GL_CNT_W = 4;

    // branch checkpoint geometry
    localparam int NUM_CHKP   = 4;
    localparam int CHKP_IDX_W = 2;
    localparam int CHKP_CNT_W = 3;

    // fetch addresses
    localparam int PC_W = 32;
    localparam logic [PC_W-1:0] XCPT_VECTOR = 32'h0000_0100;
    localparam logic [PC_W-1:0] RESET_PC    = 32'h0000_0000;

    // source of the next fetch PC
    typedef enum logic [1:0] {
        KEEP      = 2'b00,
        PLUS4     = 2'b01,
        JUMP_WB   = 2'b10,
        JUMP_XCPT = 2'b11
    } next_pc_sel_t;

    // instruction sent by the front end
    typedef struct packed {
        logic [PC_W-1:0] pc;
        logic            is_branch;
        logic            xcpt;
    } disp_t;

    // writeback of one instruction, branch outcome included
    typedef struct packed {
        logic [GL_IDX_W-1:0]   gl_index;
        logic                  is_branch;
        logic [CHKP_IDX_W-1:0] chkp;
        logic                  mispredicted;
        logic [PC_W-1:0]       target;
    } wb_t;

    // retired instruction
    typedef struct packed {
        logic [PC_W-1:0] pc;
        logic            xcpt;
    } commit_t;

    // head status seen by the control unit
    typedef struct packed {
        logic head_valid;
        logic head_done;
        logic head_xcpt;
    } gl_cu_t;

    typedef struct packed {
        logic enable_commit;
        logic truncate;
        logic flush_all;
    } cu_gl_t;

    typedef struct packed {
        logic                  do_checkpoint;
        logic                  do_recover;
        logic [CHKP_IDX_W-1:0] recover_chkp;
        logic                  delete_checkpoint;
        logic                  flush_all;
    } cu_chkp_t;

endpackage

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic                       clk_i,
    input  logic                       rstn_i,

    // graduation list head status
    input  ooo_ctrl_pkg::gl_cu_t       gl_cu_i,

    // writeback port
    input  logic                       wb_valid_i,
    input  ooo_ctrl_pkg::wb_t          wb_i,

    // dispatch port
    input  logic                       disp_valid_i,
    input  logic                       disp_branch_i,

    // fetch back-pressure
    input  logic                       fetch_ready_i,

    output ooo_ctrl_pkg::cu_gl_t       cu_gl_o,
    output ooo_ctrl_pkg::cu_chkp_t     cu_chkp_o,
    output ooo_ctrl_pkg::next_pc_sel_t next_pc_sel_o
);

    logic exception_d;
    logic exception_q;
    logic mispredict;
    logic correct_branch;
    logic recover;

    // exception found at the head of the graduation list
    // once exception_q is set the same head must not raise it again,
    // it is flushed at the end of that cycle
    always_comb begin
        exception_d = 1'b0;
        if (!exception_q) begin
            exception_d = gl_cu_i.head_valid & gl_cu_i.head_done & gl_cu_i.head_xcpt;
        end
    end

    // branch outcome at writeback
    assign mispredict     = wb_valid_i & wb_i.is_branch & wb_i.mispredicted;
    assign correct_branch = wb_valid_i & wb_i.is_branch & ~wb_i.mispredicted;

    // a pending exception flush overrides a misprediction in the same cycle
    assign recover = mispredict & ~exception_q;

    // graduation list control
    always_comb begin
        cu_gl_o.enable_commit = ~exception_d & ~exception_q;
        cu_gl_o.truncate      = recover;
        cu_gl_o.flush_all     = exception_q;
    end

    // checkpoint table control
    always_comb begin
        // a branch takes a checkpoint as it is dispatched
        cu_chkp_o.do_checkpoint     = disp_valid_i & disp_branch_i;
        cu_chkp_o.do_recover        = recover;
        cu_chkp_o.recover_chkp      = wb_i.chkp;
        // oldest checkpoint is no longer needed once its branch resolves
        cu_chkp_o.delete_checkpoint = correct_branch;
        cu_chkp_o.flush_all         = exception_q;
    end

    // next fetch PC, highest priority first
    always_comb begin
        if (exception_q) begin
            next_pc_sel_o = ooo_ctrl_pkg::JUMP_XCPT;
        end else if (mispredict) begin
            next_pc_sel_o = ooo_ctrl_pkg::JUMP_WB;
        end else if (fetch_ready_i) begin
            next_pc_sel_o = ooo_ctrl_pkg::PLUS4;
        end else begin
            // front end stalled, hold the current PC
            next_pc_sel_o = ooo_ctrl_pkg::KEEP;
        end
    end

    // exception is acted upon one cycle after it reaches commit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            exception_q <= 1'b0;
        end else begin
            exception_q <= exception_d;
        end
    end

endmodule

// ==== source/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  ooo_ctrl_pkg::next_pc_sel_t      next_pc_sel_i,
    input  logic [ooo_ctrl_pkg::PC_W-1:0]   wb_target_i,
    output logic                            fetch_valid_o,
    output logic [ooo_ctrl_pkg::PC_W-1:0]   fetch_pc_o
);

    logic [ooo_ctrl_pkg::PC_W-1:0] pc_d;
    logic [ooo_ctrl_pkg::PC_W-1:0] pc_q;
    logic                          fetch_valid_q;

    // next PC multiplexer
    always_comb begin
        case (next_pc_sel_i)
            ooo_ctrl_pkg::KEEP:      pc_d = pc_q;
            ooo_ctrl_pkg::PLUS4:     pc_d = pc_q + ooo_ctrl_pkg::PC_W'(4);
            ooo_ctrl_pkg::JUMP_WB:   pc_d = wb_target_i;
            ooo_ctrl_pkg::JUMP_XCPT: pc_d = ooo_ctrl_pkg::XCPT_VECTOR;
            default:                 pc_d = pc_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q          <= ooo_ctrl_pkg::RESET_PC;
            fetch_valid_q <= 1'b0;
        end else begin
            pc_q          <= pc_d;
            // fetch starts in the first cycle after reset
            fetch_valid_q <= 1'b1;
        end
    end

    assign fetch_valid_o = fetch_valid_q;
    assign fetch_pc_o    = pc_q;

endmodule

// ==== source/checkpoint_table.sv ====
`timescale 1ns/1ps

module checkpoint_table (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  ooo_ctrl_pkg::cu_chkp_t                cu_chkp_i,
    input  logic [ooo_ctrl_pkg::GL_IDX_W-1:0]     gl_tail_i,
    output logic [ooo_ctrl_pkg::GL_IDX_W-1:0]     saved_tail_o,
    output logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0]   chkp_credit_o
);

    // saved graduation-list tail per checkpoint
    logic [ooo_ctrl_pkg::GL_IDX_W-1:0]   saved_q [ooo_ctrl_pkg::NUM_CHKP];

    logic [ooo_ctrl_pkg::CHKP_IDX_W-1:0] tail_q;
    logic [ooo_ctrl_pkg::CHKP_IDX_W-1:0] tail_d;
    logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0] count_q;
    logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0] count_d;
    logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0] count_in;
    logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0] credit_q;
    logic                                release_head;

    // a correctly predicted branch frees the oldest checkpoint
    assign release_head = cu_chkp_i.delete_checkpoint & (count_q != '0);
    assign count_in     = count_q + ooo_ctrl_pkg::CHKP_CNT_W'(cu_chkp_i.do_checkpoint);

    always_comb begin
        tail_d  = tail_q;
        count_d = count_in;
        if (cu_chkp_i.flush_all) begin
            tail_d  = '0;
            count_d = '0;
        end else if (cu_chkp_i.do_recover) begin
            // branches resolve oldest first so the recovered id is the oldest one
            // it is released together with all younger ones
            tail_d  = cu_chkp_i.recover_chkp + 1'b1;
            count_d = '0;
        end else begin
            tail_d  = tail_q + ooo_ctrl_pkg::CHKP_IDX_W'(cu_chkp_i.do_checkpoint);
            count_d = count_in - ooo_ctrl_pkg::CHKP_CNT_W'(release_head);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tail_q   <= '0;
            count_q  <= '0;
            credit_q <= '0;
        end else begin
            tail_q   <= tail_d;
            count_q  <= count_d;
            // allocated this cycle but dropped also counts as freed
            credit_q <= count_in - count_d;
        end
    end

    // the branch sits at the current tail
    // its younger entries start one later
    always_ff @(posedge clk_i) begin
        if (cu_chkp_i.do_checkpoint) begin
            saved_q[tail_q] <= gl_tail_i + 1'b1;
        end
    end

    assign saved_tail_o  = saved_q[cu_chkp_i.recover_chkp];
    assign chkp_credit_o = credit_q;

endmodule

// ==== source/graduation_list.sv ====
`timescale 1ns/1ps

module graduation_list (
    input  logic                                clk_i,
    input  logic                                rstn_i,

    // dispatch and writeback
    input  logic                                disp_valid_i,
    input  ooo_ctrl_pkg::disp_t                 disp_i,
    input  logic                                wb_valid_i,
    input  logic [ooo_ctrl_pkg::GL_IDX_W-1:0]   wb_gl_index_i,

    // control and recovery
    input  ooo_ctrl_pkg::cu_gl_t                cu_gl_i,
    input  logic [ooo_ctrl_pkg::GL_IDX_W-1:0]   saved_tail_i,
    output ooo_ctrl_pkg::gl_cu_t                gl_cu_o,
    output logic [ooo_ctrl_pkg::GL_IDX_W-1:0]   gl_tail_o,

    // commit and credit return
    output logic                                commit_valid_o,
    output ooo_ctrl_pkg::commit_t               commit_o,
    output logic [ooo_ctrl_pkg::GL_CNT_W-1:0]   gl_credit_o
);

    // pc and exception flag per entry
    ooo_ctrl_pkg::commit_t                entry_q [ooo_ctrl_pkg::GL_DEPTH];
    logic [ooo_ctrl_pkg::GL_DEPTH-1:0]    done_q;

    logic [ooo_ctrl_pkg::GL_IDX_W-1:0]    head_q, head_d;
    logic [ooo_ctrl_pkg::GL_IDX_W-1:0]    tail_q, tail_d;
    logic [ooo_ctrl_pkg::GL_IDX_W-1:0]    keep_span;
    logic [ooo_ctrl_pkg::GL_CNT_W-1:0]    count_q, count_d;
    logic [ooo_ctrl_pkg::GL_CNT_W-1:0]    count_in;
    logic [ooo_ctrl_pkg::GL_CNT_W-1:0]    credit_q;
    logic                                 head_valid;
    logic                                 head_done;
    logic                                 retire;

    assign head_valid = (count_q != '0);
    assign head_done  = done_q[head_q];

    always_comb begin
        gl_cu_o.head_valid = head_valid;
        gl_cu_o.head_done  = head_done;
        gl_cu_o.head_xcpt  = entry_q[head_q].xcpt;
    end

    // an excepting head is reported once but never retires
    assign retire         = head_valid & head_done & cu_gl_i.enable_commit;
    assign commit_valid_o = head_valid & head_done &
                            (cu_gl_i.enable_commit | (entry_q[head_q].xcpt & ~cu_gl_i.flush_all));
    assign commit_o       = entry_q[head_q];

    assign count_in = count_q + ooo_ctrl_pkg::GL_CNT_W'(disp_valid_i);

    always_comb begin
        head_d    = head_q + ooo_ctrl_pkg::GL_IDX_W'(retire);
        tail_d    = tail_q + ooo_ctrl_pkg::GL_IDX_W'(disp_valid_i);
        count_d   = count_in - ooo_ctrl_pkg::GL_CNT_W'(retire);
        // entries older than the branch, the branch itself adds one
        keep_span = saved_tail_i - 1'b1 - head_d;
        if (cu_gl_i.flush_all) begin
            head_d  = '0;
            tail_d  = '0;
            count_d = '0;
        end else if (cu_gl_i.truncate) begin
            tail_d  = saved_tail_i;
            count_d = {1'b0, keep_span} + ooo_ctrl_pkg::GL_CNT_W'(1);
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q   <= '0;
            tail_q   <= '0;
            count_q  <= '0;
            credit_q <= '0;
            done_q   <= '0;
        end else begin
            head_q   <= head_d;
            tail_q   <= tail_d;
            count_q  <= count_d;
            // retired, truncated and flushed entries, same-cycle dispatch included
            credit_q <= count_in - count_d;
            if (disp_valid_i) begin
                done_q[tail_q] <= 1'b0;
            end
            if (wb_valid_i) begin
                done_q[wb_gl_index_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (disp_valid_i) begin
            entry_q[tail_q].pc   <= disp_i.pc;
            entry_q[tail_q].xcpt <= disp_i.xcpt;
        end
    end

    assign gl_tail_o   = tail_q;
    assign gl_credit_o = credit_q;

endmodule

// ==== source/ooo_ctrl_top.sv ====
`timescale 1ns/1ps

module ooo_ctrl_top (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,

    // dispatch from the front end
    input  logic                                  disp_valid_i,
    input  ooo_ctrl_pkg::disp_t                   disp_i,

    // writeback
    input  logic                                  wb_valid_i,
    input  ooo_ctrl_pkg::wb_t                     wb_i,

    // fetch
    input  logic                                  fetch_ready_i,

    // credit return
    output logic [ooo_ctrl_pkg::GL_CNT_W-1:0]     gl_credit_o,
    output logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0]   chkp_credit_o,

    // commit
    output logic                                  commit_valid_o,
    output ooo_ctrl_pkg::commit_t                 commit_o,

    output logic                                  fetch_valid_o,
    output logic [ooo_ctrl_pkg::PC_W-1:0]         fetch_pc_o
);

    ooo_ctrl_pkg::gl_cu_t              gl_cu;
    ooo_ctrl_pkg::cu_gl_t              cu_gl;
    ooo_ctrl_pkg::cu_chkp_t            cu_chkp;
    ooo_ctrl_pkg::next_pc_sel_t        next_pc_sel;
    logic [ooo_ctrl_pkg::GL_IDX_W-1:0] gl_tail;
    logic [ooo_ctrl_pkg::GL_IDX_W-1:0] saved_tail;

    control_unit control_unit_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .gl_cu_i       (gl_cu),
        .wb_valid_i    (wb_valid_i),
        .wb_i          (wb_i),
        .disp_valid_i  (disp_valid_i),
        .disp_branch_i (disp_i.is_branch),
        .fetch_ready_i (fetch_ready_i),
        .cu_gl_o       (cu_gl),
        .cu_chkp_o     (cu_chkp),
        .next_pc_sel_o (next_pc_sel)
    );

    pc_gen pc_gen_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .next_pc_sel_i (next_pc_sel),
        .wb_target_i   (wb_i.target),
        .fetch_valid_o (fetch_valid_o),
        .fetch_pc_o    (fetch_pc_o)
    );

    checkpoint_table checkpoint_table_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .cu_chkp_i     (cu_chkp),
        .gl_tail_i     (gl_tail),
        .saved_tail_o  (saved_tail),
        .chkp_credit_o (chkp_credit_o)
    );

    graduation_list graduation_list_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .disp_valid_i   (disp_valid_i),
        .disp_i         (disp_i),
        .wb_valid_i     (wb_valid_i),
        .wb_gl_index_i  (wb_i.gl_index),
        .cu_gl_i        (cu_gl),
        .saved_tail_i   (saved_tail),
        .gl_cu_o        (gl_cu),
        .gl_tail_o      (gl_tail),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .gl_credit_o    (gl_credit_o)
    );

endmodule

// ==== tests/ooo_ctrl_asserts.sv ====
`timescale 1ns/1ps

module ooo_ctrl_asserts (
    input  logic                                  clk_i,
    input  logic                                  rstn_i,
    input  logic                                  disp_valid_i,
    input  ooo_ctrl_pkg::disp_t                   disp_i,
    input  logic                                  wb_valid_i,
    input  ooo_ctrl_pkg::wb_t                     wb_i,
    input  logic                                  fetch_ready_i,
    input  logic [ooo_ctrl_pkg::GL_CNT_W-1:0]     gl_credit_o,
    input  logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0]   chkp_credit_o,
    input  logic                                  commit_valid_o,
    input  ooo_ctrl_pkg::commit_t                 commit_o,
    input  logic                                  fetch_valid_o,
    input  logic [ooo_ctrl_pkg::PC_W-1:0]         fetch_pc_o
);

    int   error_count = 0;
    // credits held by the front end's instructions that have not come back yet
    int   gl_out_q;
    int   chkp_out_q;
    logic xcpt_q;
    logic mispredict;
    logic xcpt_commit;

    assign mispredict  = wb_valid_i & wb_i.is_branch & wb_i.mispredicted;
    assign xcpt_commit = commit_valid_o & commit_o.xcpt;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            gl_out_q   <= 0;
            chkp_out_q <= 0;
            xcpt_q     <= 1'b0;
        end else begin
            gl_out_q   <= gl_out_q + int'(disp_valid_i) - int'(gl_credit_o);
            chkp_out_q <= chkp_out_q + int'(disp_valid_i & disp_i.is_branch) - int'(chkp_credit_o);
            // mirrors the exception delay register of the control unit
            xcpt_q     <= xcpt_commit;
        end
    end

    reset_quiet: assert property (@(posedge clk_i)
        !rstn_i |-> !fetch_valid_o && !commit_valid_o && gl_credit_o == '0 && chkp_credit_o == '0)
        else begin
            $error("outputs active during reset");
            error_count = error_count + 1;
        end

    // first cycle out of reset
    reset_release: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> (!fetch_valid_o && gl_credit_o == '0 && chkp_credit_o == '0)
        ##1 fetch_valid_o)
        else begin
            $error("fetch valid or credits wrong after reset release");
            error_count = error_count + 1;
        end

    pc_advance: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_ready_i && !mispredict && !xcpt_q |=> fetch_pc_o == $past(fetch_pc_o) + 32'd4)
        else begin
            $error("fetch pc did not advance by 4");
            error_count = error_count + 1;
        end

    pc_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !fetch_ready_i && !mispredict && !xcpt_q |=> fetch_pc_o == $past(fetch_pc_o))
        else begin
            $error("fetch pc moved while stalled");
            error_count = error_count + 1;
        end

    pc_redirect: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mispredict && !xcpt_q |=> fetch_pc_o == $past(wb_i.target))
        else begin
            $error("fetch pc is not the writeback target after a misprediction");
            error_count = error_count + 1;
        end

    // exception flush returns every outstanding credit
    xcpt_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        xcpt_commit |=> !commit_valid_o ##1 (fetch_pc_o == ooo_ctrl_pkg::XCPT_VECTOR &&
        gl_out_q == int'(gl_credit_o) && chkp_out_q == int'(chkp_credit_o)))
        else begin
            $error("exception did not flush and redirect fetch");
            error_count = error_count + 1;
        end

    credit_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        gl_out_q >= 0 && gl_out_q <= ooo_ctrl_pkg::GL_DEPTH &&
        chkp_out_q >= 0 && chkp_out_q <= ooo_ctrl_pkg::NUM_CHKP)
        else begin
            $error("outstanding credits out of range");
            error_count = error_count + 1;
        end

endmodule

// ==== tests/tb_ooo_ctrl.sv ====
`timescale 1ns/1ps

module tb_ooo_ctrl;

    localparam int CLK_PERIOD  = 20;
    localparam int TEST_CYCLES = 300;
    localparam int DRAIN_MAX   = 200;
    localparam int NUM_TESTS   = 4;

    // front-end view of one in-flight instruction
    typedef struct packed {
        logic [ooo_ctrl_pkg::PC_W-1:0]       pc;
        logic [ooo_ctrl_pkg::GL_IDX_W-1:0]   gl_index;
        logic                                is_branch;
        logic [ooo_ctrl_pkg::CHKP_IDX_W-1:0] chkp;
        logic                                xcpt;
        logic                                done;
    } entry_t;

    logic                                clk_i;
    logic                                rstn_i;
    logic                                disp_valid_i;
    ooo_ctrl_pkg::disp_t                 disp_i;
    logic                                wb_valid_i;
    ooo_ctrl_pkg::wb_t                   wb_i;
    logic                                fetch_ready_i;
    logic [ooo_ctrl_pkg::GL_CNT_W-1:0]   gl_credit_o;
    logic [ooo_ctrl_pkg::CHKP_CNT_W-1:0] chkp_credit_o;
    logic                                commit_valid_o;
    ooo_ctrl_pkg::commit_t               commit_o;
    logic                                fetch_valid_o;
    logic [ooo_ctrl_pkg::PC_W-1:0]       fetch_pc_o;

    // oldest instruction at the front
    entry_t                              live_q[$];
    logic [15:0]                         lfsr_q;
    string                               cur_test;
    int                                  errors;
    int                                  tests_run;
    int                                  gl_cred;
    int                                  chkp_cred;
    int                                  chkp_live;
    int                                  exp_gl;
    int                                  exp_chkp;
    int                                  wb_pos;
    logic                                flush_pending;
    logic                                branch_en;
    logic                                mispred_en;
    logic                                xcpt_en;
    logic [ooo_ctrl_pkg::GL_IDX_W-1:0]   gl_tail;
    logic [ooo_ctrl_pkg::CHKP_IDX_W-1:0] chkp_tail;
    logic [ooo_ctrl_pkg::PC_W-1:0]       next_pc;

    ooo_ctrl_top uut (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .disp_valid_i   (disp_valid_i),
        .disp_i         (disp_i),
        .wb_valid_i     (wb_valid_i),
        .wb_i           (wb_i),
        .fetch_ready_i  (fetch_ready_i),
        .gl_credit_o    (gl_credit_o),
        .chkp_credit_o  (chkp_credit_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_pc_o     (fetch_pc_o)
    );

    bind ooo_ctrl_top ooo_ctrl_asserts asserts_inst (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .disp_valid_i   (disp_valid_i),
        .disp_i         (disp_i),
        .wb_valid_i     (wb_valid_i),
        .wb_i           (wb_i),
        .fetch_ready_i  (fetch_ready_i),
        .gl_credit_o    (gl_credit_o),
        .chkp_credit_o  (chkp_credit_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o),
        .fetch_valid_o  (fetch_valid_o),
        .fetch_pc_o     (fetch_pc_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        int i;
        v = 0;
        for (i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        errors++;
    endtask

    // compare with the model at the falling edge, then apply this cycle's events
    task automatic check_outputs();
        int     freed_gl;
        int     freed_chkp;
        int     pos;
        entry_t e;
        freed_gl   = 0;
        freed_chkp = 0;
        pos        = wb_pos;
        if (gl_credit_o !== exp_gl) report_mismatch("gl_credit_o", exp_gl, gl_credit_o);
        if (chkp_credit_o !== exp_chkp) report_mismatch("chkp_credit_o", exp_chkp, chkp_credit_o);
        gl_cred   += gl_credit_o;
        chkp_cred += chkp_credit_o;
        if (flush_pending) begin
            if (commit_valid_o) report_error("commit during an exception flush");
            freed_gl   = live_q.size();
            freed_chkp = chkp_live;
            live_q.delete();
            chkp_live     = 0;
            gl_tail       = '0;
            chkp_tail     = '0;
            flush_pending = 1'b0;
        end else begin
            if (commit_valid_o) begin
                if (live_q.size() == 0) begin
                    report_error("commit from an empty buffer");
                end else begin
                    if (commit_o.pc !== live_q[0].pc) begin
                        report_mismatch("commit pc", live_q[0].pc, commit_o.pc);
                    end
                    if (commit_o.xcpt !== live_q[0].xcpt) begin
                        report_mismatch("commit xcpt", live_q[0].xcpt, commit_o.xcpt);
                    end
                    if (!live_q[0].done) report_error("commit before writeback");
                    if (commit_o.xcpt) begin
                        flush_pending = 1'b1;
                    end else begin
                        void'(live_q.pop_front());
                        freed_gl++;
                        pos--;
                    end
                end
            end else if (live_q.size() > 0 && live_q[0].done) begin
                report_error("written-back head did not commit");
            end
            if (wb_pos >= 0) begin
                e      = live_q[pos];
                e.done = 1'b1;
                live_q[pos] = e;
                if (e.is_branch && wb_i.mispredicted) begin
                    // younger entries squashed, every checkpoint released
                    while (live_q.size() > pos + 1) begin
                        void'(live_q.pop_back());
                        freed_gl++;
                    end
                    freed_chkp += chkp_live;
                    chkp_live   = 0;
                    gl_tail     = e.gl_index + 1'b1;
                    chkp_tail   = e.chkp + 1'b1;
                end else if (e.is_branch) begin
                    freed_chkp++;
                    chkp_live--;
                end
            end
        end
        exp_gl   = freed_gl;
        exp_chkp = freed_chkp;
    endtask

    task automatic run_cycle(input logic disp_en);
        int     r;
        int     pos;
        int     j;
        entry_t e;
        @(posedge clk_i);
        #2;
        disp_valid_i = 1'b0;
        wb_valid_i   = 1'b0;
        wb_pos       = -1;
        take_bits(2, r);
        fetch_ready_i = (r != 0);
        if (!flush_pending && live_q.size() > 0) begin
            take_bits(3, r);
            pos = r % live_q.size();
            // branches resolve in program order
            if (live_q[pos].is_branch) begin
                j = 0;
                while (j < pos && !(live_q[j].is_branch && !live_q[j].done)) begin
                    j++;
                end
                pos = j;
            end
            if (!live_q[pos].done) begin
                take_bits(2, r);
                wb_valid_i        = 1'b1;
                wb_i.gl_index     = live_q[pos].gl_index;
                wb_i.is_branch    = live_q[pos].is_branch;
                wb_i.chkp         = live_q[pos].chkp;
                wb_i.mispredicted = live_q[pos].is_branch & mispred_en & (r == 0);
                take_bits(8, r);
                wb_i.target       = {22'h0, r[7:0], 2'b00};
                wb_pos            = pos;
            end
        end
        take_bits(1, r);
        if (disp_en && !flush_pending && r[0] && gl_cred > 0) begin
            e = '0;
            take_bits(2, r);
            e.is_branch = branch_en && (r == 0) && (chkp_cred > 0);
            take_bits(4, r);
            e.xcpt      = xcpt_en && (r == 0);
            e.pc        = next_pc;
            e.gl_index  = gl_tail;
            e.chkp      = chkp_tail;
            disp_valid_i     = 1'b1;
            disp_i.pc        = e.pc;
            disp_i.is_branch = e.is_branch;
            disp_i.xcpt      = e.xcpt;
            live_q.push_back(e);
            next_pc += 32'd4;
            gl_tail++;
            gl_cred--;
            if (e.is_branch) begin
                chkp_tail++;
                chkp_cred--;
                chkp_live++;
            end
        end
        @(negedge clk_i);
        check_outputs();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((live_q.size() > 0 || flush_pending || exp_gl != 0 || exp_chkp != 0) &&
               n < DRAIN_MAX) begin
            run_cycle(1'b0);
            n++;
        end
        if (live_q.size() > 0) report_error("buffer did not drain");
        if (gl_cred != ooo_ctrl_pkg::GL_DEPTH || chkp_cred != ooo_ctrl_pkg::NUM_CHKP) begin
            report_error("credits not all returned after drain");
        end
    endtask

    task automatic run_test(input string name, input logic disp, input logic br,
                            input logic mp, input logic xc);
        int start_errors;
        int i;
        start_errors = errors + uut.asserts_inst.error_count;
        cur_test     = name;
        branch_en    = br;
        mispred_en   = mp;
        xcpt_en      = xc;
        for (i = 0; i < TEST_CYCLES; i++) begin
            run_cycle(disp);
        end
        drain();
        tests_run++;
        $display("test %s done, %0d errors", name,
                 errors + uut.asserts_inst.error_count - start_errors);
    endtask

    initial begin
        rstn_i        = 1'b0;
        disp_valid_i  = 1'b0;
        disp_i        = '0;
        wb_valid_i    = 1'b0;
        wb_i          = '0;
        fetch_ready_i = 1'b0;
        lfsr_q        = 16'd30;
        errors        = 0;
        tests_run     = 0;
        gl_cred       = ooo_ctrl_pkg::GL_DEPTH;
        chkp_cred     = ooo_ctrl_pkg::NUM_CHKP;
        chkp_live     = 0;
        exp_gl        = 0;
        exp_chkp      = 0;
        wb_pos        = -1;
        flush_pending = 1'b0;
        branch_en     = 1'b0;
        mispred_en    = 1'b0;
        xcpt_en       = 1'b0;
        gl_tail       = '0;
        chkp_tail     = '0;
        next_pc       = 32'h0000_1000;
        repeat (3) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;
        run_test("reset_fetch", 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("dispatch_drain", 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("branch_recover", 1'b1, 1'b1, 1'b1, 1'b0);
        run_test("exception_flush", 1'b1, 1'b1, 1'b1, 1'b1);
        errors = errors + uut.asserts_inst.error_count;
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // every test runs its cycles plus at most a full drain
    initial begin
        #((NUM_TESTS * (TEST_CYCLES + DRAIN_MAX) + 3) * CLK_PERIOD + 1000);
        $display("watchdog: the run timed out before all tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== ooo_ctrl.f ====
source/ooo_ctrl_pkg.sv
source/control_unit.sv
source/pc_gen.sv
source/checkpoint_table.sv
source/graduation_list.sv
source/ooo_ctrl_top.sv
tests/ooo_ctrl_asserts.sv
tests/tb_ooo_ctrl.sv
